// File: src/vt_pkg.sv
// Shared widths, types and constants for the raster timing generator; referenced by scoped name
package vt_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths

   localparam int COORD_W   = 11;              // H/V counter range
   localparam int WORD_W    = 32;              // DMA word
   localparam int BPP_W     = 2;               // Depth code
   localparam int RGB_W     = 12;              // Palette entry, 4 bits per channel
   localparam int CHAN_W    = 8;               // Output channel
   localparam int PAL_IDX_W = 4;

   // Counter value or threshold
   typedef logic [COORD_W-1:0]   coord_t;
   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [BPP_W-1:0]     bpp_t;
   // Red 3..0, green 7..4, blue 11..8
   typedef logic [RGB_W-1:0]     rgb12_t;
   typedef logic [CHAN_W-1:0]    chan8_t;
   typedef logic [PAL_IDX_W-1:0] pal_idx_t;

   ////////////////////////////////////////////////////////////////////////////
   // Pixel depth codes

   localparam bpp_t BPP_1 = 2'd0;              // 32 pixels per word
   localparam bpp_t BPP_2 = 2'd1;              // 16 pixels per word
   localparam bpp_t BPP_4 = 2'd2;              // 8 pixels per word, code 3 same

   ////////////////////////////////////////////////////////////////////////////
   // Pipeline and resync

   localparam int PAL_ENTRIES = 16;
   // Raw scan signals to outputs
   localparam int PIPE_DEPTH  = 4;
   // Minimum held cycles before release
   localparam int RESYNC_HOLD = 3;

   // Resync FSM
   typedef enum logic [1:0] {
      ST_RUN,                                  // Free running raster
      ST_HOLD,                                 // Scan held, thresholds loading
      ST_WAIT_FB                               // Waiting for flyback fall
   } sync_state_t;

endpackage

// File: src/vt_timing_if.sv
// Timing thresholds and run enable, driven by the register block and read by scan and pixel logic
`timescale 1ns/100ps

interface vt_timing_if;

   // Last coordinate of each horizontal phase
   vt_pkg::coord_t h_sync_off;
   vt_pkg::coord_t h_disp_start;
   vt_pkg::coord_t h_disp_end;
   vt_pkg::coord_t h_total;
   // Same for vertical, in lines
   vt_pkg::coord_t v_sync_off;
   vt_pkg::coord_t v_disp_start;
   vt_pkg::coord_t v_disp_end;
   vt_pkg::coord_t v_total;
   vt_pkg::bpp_t   bpp;                        // Depth code
   logic           run;                        // Scan enable

   modport cfg (
      output h_sync_off, h_disp_start, h_disp_end, h_total,
      output v_sync_off, v_disp_start, v_disp_end, v_total,
      output bpp, run
   );

   modport scan (
      input h_sync_off, h_disp_start, h_disp_end, h_total,
      input v_sync_off, v_disp_start, v_disp_end, v_total,
      input run
   );

   modport pix (input bpp);

endinterface

// File: src/vt_timing_regs.sv
// Timing capture via req/ack toggle handshake; holds the scan and releases it on a flyback fall
`timescale 1ns/100ps

module vt_timing_regs (
   input  logic           pclk,
   input  logic           i_reset,
   input  logic           i_cfg_req,           // Toggled when i_t_* are stable
   input  logic           i_flyback,           // Async
   input  vt_pkg::coord_t i_t_h_res,
   input  vt_pkg::coord_t i_t_h_fp,
   input  vt_pkg::coord_t i_t_h_sync,
   input  vt_pkg::coord_t i_t_h_bp,
   input  vt_pkg::coord_t i_t_v_res,
   input  vt_pkg::coord_t i_t_v_fp,
   input  vt_pkg::coord_t i_t_v_sync,
   input  vt_pkg::coord_t i_t_v_bp,
   input  vt_pkg::bpp_t   i_t_bpp,
   output logic           o_cfg_ack,
   output logic           o_frame_start,       // One cycle per flyback fall
   vt_timing_if.cfg       tim
);

   localparam int HOLD_W = $clog2(vt_pkg::RESYNC_HOLD + 1);

   logic [1:0]          req_sync;              // Two-flop request sync
   logic [2:0]          fb_sync;               // Two sync flops plus last value
   logic                req_pending;
   logic                fb_fall;
   logic                run;
   logic [HOLD_W-1:0]   hold_cnt;
   vt_pkg::sync_state_t state;

   always_ff @(posedge pclk) begin
      if (i_reset) begin
         req_sync <= '0;
         fb_sync  <= '0;
      end else begin
         req_sync <= {req_sync[0], i_cfg_req};
         fb_sync  <= {fb_sync[1:0], i_flyback};
      end
   end

   assign req_pending   = req_sync[1] != o_cfg_ack;
   assign fb_fall       = fb_sync[2] & ~fb_sync[1]; // Edge seen on third flop
   assign o_frame_start = fb_fall;
   assign tim.run       = run;

   ////////////////////////////////////////////////////////////////////////////
   // Resync FSM

   always_ff @(posedge pclk) begin
      if (i_reset) begin
         state     <= vt_pkg::ST_HOLD;         // Start scanning at first flyback fall
         hold_cnt  <= HOLD_W'(vt_pkg::RESYNC_HOLD - 1);
         run       <= 1'b0;
         o_cfg_ack <= 1'b0;
      end else begin
         case (state)
            vt_pkg::ST_RUN: if (req_pending) begin
               state    <= vt_pkg::ST_HOLD;
               hold_cnt <= HOLD_W'(vt_pkg::RESYNC_HOLD - 1);
               run      <= 1'b0;               // Stop the raster
            end
            vt_pkg::ST_HOLD: begin
               if (hold_cnt == '0)
                  state <= vt_pkg::ST_WAIT_FB;
               else
                  hold_cnt <= hold_cnt - 1'b1;
            end
            vt_pkg::ST_WAIT_FB: if (fb_fall) begin
               run       <= 1'b1;
               o_cfg_ack <= req_sync[1];       // Toggles only if a request is open
               state     <= vt_pkg::ST_RUN;
            end
            default: state <= vt_pkg::ST_HOLD;
         endcase
      end
   end

   // Thresholds are last coordinate of each phase; loaded only while held
   always_ff @(posedge pclk) begin
      if (!run) begin
         tim.h_sync_off   <= i_t_h_sync - 1'b1;
         tim.h_disp_start <= i_t_h_sync + i_t_h_bp - 1'b1;
         tim.h_disp_end   <= i_t_h_sync + i_t_h_bp + i_t_h_res - 1'b1;
         tim.h_total      <= i_t_h_sync + i_t_h_bp + i_t_h_res + i_t_h_fp - 1'b1;
         tim.v_sync_off   <= i_t_v_sync - 1'b1;
         tim.v_disp_start <= i_t_v_sync + i_t_v_bp - 1'b1;
         tim.v_disp_end   <= i_t_v_sync + i_t_v_bp + i_t_v_res - 1'b1;
         tim.v_total      <= i_t_v_sync + i_t_v_bp + i_t_v_res + i_t_v_fp - 1'b1;
         tim.bpp          <= i_t_bpp;
      end
   end

   // Ack moves only on the release out of the flyback wait
   a_ack_on_release: assert property (@(posedge pclk) disable iff (i_reset)
      $changed(o_cfg_ack) |-> $past(state) == vt_pkg::ST_WAIT_FB);

endmodule

// File: src/vt_scan_counter.sv
// Horizontal and vertical raster counters producing raw syncs, display enable and coordinates
`timescale 1ns/100ps

module vt_scan_counter (
   input  logic           pclk,
   input  logic           i_reset,
   vt_timing_if.scan      tim,
   output logic           o_de,                // Raw, before the pixel pipeline
   output logic           o_hsync,
   output logic           o_vsync,
   output vt_pkg::coord_t o_disp_x,            // Valid while o_de
   output vt_pkg::coord_t o_disp_y
);

   vt_pkg::coord_t px;                         // Pixel within line
   vt_pkg::coord_t py;                         // Line within frame
   logic           line_end;
   logic           frame_end;
   logic           h_disp;
   logic           v_disp;

   ////////////////////////////////////////////////////////////////////////////
   // Phase decode

   // Syncs sit at coordinate 0; display starts one past the back porch
   assign line_end  = px == tim.h_total;
   assign frame_end = py == tim.v_total;
   assign h_disp    = (px > tim.h_disp_start) && (px <= tim.h_disp_end);
   assign v_disp    = (py > tim.v_disp_start) && (py <= tim.v_disp_end);

   ////////////////////////////////////////////////////////////////////////////
   // Counters

   always_ff @(posedge pclk) begin
      if (i_reset) begin
         px       <= '0;
         py       <= '0;
         o_disp_y <= '0;
      end else if (!tim.run) begin
         // Held on the line before the first display line
         px       <= '0;
         py       <= tim.v_disp_start;
         o_disp_y <= '0;
      end else if (line_end) begin
         px <= '0;
         if (frame_end)
            py <= '0;                          // Wrap into vsync
         else
            py <= py + 1'b1;

         // Display line count
         if (py == tim.v_disp_end)
            o_disp_y <= '0;                    // Last display line done
         else if (v_disp)
            o_disp_y <= o_disp_y + 1'b1;
      end else begin
         px <= px + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Raw outputs

   // All low while the scan is held
   assign o_hsync  = tim.run && (px <= tim.h_sync_off);
   assign o_vsync  = tim.run && (py <= tim.v_sync_off);
   assign o_de     = tim.run && h_disp && v_disp;

   // Zero at first displayed pixel
   assign o_disp_x = px - tim.h_disp_start - 1'b1;

   // Counter must wrap at the programmed total
   a_px_in_line: assert property (@(posedge pclk) disable iff (i_reset)
      tim.run |-> px <= tim.h_total);

endmodule

// File: src/vt_line_buffer.sv
// Two-bank line RAM; DMA fills alternate banks per line, scan-out reads with one cycle latency
`timescale 1ns/100ps

module vt_line_buffer #(
   parameter int BANK_AW = 8                   // Words per bank is 2**BANK_AW
) (
   input  logic               pclk,
   input  logic               i_reset,
   input  logic               i_frame_start,   // Restart at bank 0 word 0
   input  logic               i_dma_valid,     // No back-pressure
   input  vt_pkg::word_t      i_dma_data,
   input  logic [BANK_AW-1:0] i_words_per_line_m1,
   input  logic [BANK_AW:0]   i_rd_addr,       // {bank, word}
   output vt_pkg::word_t      o_rd_data
);

   vt_pkg::word_t      mem [2**(BANK_AW+1)];
   logic [BANK_AW:0]   wr_ptr;                 // Bank bit on top
   logic [BANK_AW:0]   wr_addr;
   logic [BANK_AW:0]   wr_next;

   // A word arriving with frame start lands at bank 0 word 0
   assign wr_addr = i_frame_start ? '0 : wr_ptr;

   // Flip bank after the last word of a line
   assign wr_next = (wr_addr[BANK_AW-1:0] == i_words_per_line_m1) ?
                    {~wr_addr[BANK_AW], {BANK_AW{1'b0}}} :
                    wr_addr + 1'b1;

   always_ff @(posedge pclk) begin
      if (i_reset)
         wr_ptr <= '0;
      else if (i_dma_valid)
         wr_ptr <= wr_next;
      else if (i_frame_start)
         wr_ptr <= '0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // RAM

   always_ff @(posedge pclk) begin
      if (i_dma_valid)
         mem[wr_addr] <= i_dma_data;
      o_rd_data <= mem[i_rd_addr];             // Registered read
   end

   // Pointer never runs past the programmed line length
   a_ptr_in_line: assert property (@(posedge pclk) disable iff (i_reset)
      wr_ptr[BANK_AW-1:0] <= i_words_per_line_m1);

endmodule

// File: src/vt_pixel_unpack.sv
// Four-stage pixel pipeline; line buffer read, bit select, palette lookup, colour expand
`timescale 1ns/100ps

module vt_pixel_unpack #(
   parameter int BANK_AW = 8
) (
   input  logic               pclk,
   input  logic               i_reset,
   vt_timing_if.pix           tim,
   input  logic               i_de,            // Raw scan signals
   input  logic               i_hsync,
   input  logic               i_vsync,
   input  vt_pkg::coord_t     i_disp_x,
   input  vt_pkg::coord_t     i_disp_y,
   input  logic [vt_pkg::PAL_ENTRIES*vt_pkg::RGB_W-1:0] i_palette,
   output logic [BANK_AW:0]   o_rd_addr,       // To line buffer
   input  vt_pkg::word_t      i_rd_data,       // One cycle after o_rd_addr
   output vt_pkg::chan8_t     o_r,
   output vt_pkg::chan8_t     o_g,
   output vt_pkg::chan8_t     o_b,
   output logic               o_hsync,
   output logic               o_vsync,
   output logic               o_de,
   output logic               o_blank
);

   localparam int PD = vt_pkg::PIPE_DEPTH;

   vt_pkg::coord_t   word_idx;
   logic [4:0]       xidx_s1;                  // Pixel position in word
   logic [4:0]       bit_sh;
   logic [3:0]       bit_mask;
   vt_pkg::word_t    shifted;
   vt_pkg::pal_idx_t pix_s2;
   vt_pkg::rgb12_t   rgb_s3;
   logic [PD-1:0]    de_pipe;
   logic [PD-1:0]    hs_pipe;
   logic [PD-1:0]    vs_pipe;

   // 4-bit channel to 8 by repeating its top bit
   function automatic vt_pkg::chan8_t widen(input logic [3:0] n);
      return {n, {4{n[3]}}};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stage 1 line buffer read

   always_comb begin
      case (tim.bpp)
         vt_pkg::BPP_1: word_idx = i_disp_x >> 5;
         vt_pkg::BPP_2: word_idx = i_disp_x >> 4;
         default:       word_idx = i_disp_x >> 3; // 4 bpp and reserved
      endcase
   end

   assign o_rd_addr = {i_disp_y[0], word_idx[BANK_AW-1:0]}; // Even lines in bank 0

   always_ff @(posedge pclk)
      xidx_s1 <= i_disp_x[4:0];

   ////////////////////////////////////////////////////////////////////////////
   // Stage 2 bit select

   always_comb begin
      case (tim.bpp)
         vt_pkg::BPP_1: begin
            bit_sh   = xidx_s1;
            bit_mask = 4'h1;
         end
         vt_pkg::BPP_2: begin
            bit_sh   = {xidx_s1[3:0], 1'b0};
            bit_mask = 4'h3;
         end
         default: begin
            bit_sh   = {xidx_s1[2:0], 2'b00};
            bit_mask = 4'hf;
         end
      endcase
   end

   assign shifted = i_rd_data >> bit_sh;       // Pixel 0 in low bits

   // Stage 3 palette and stage 4 expand
   always_ff @(posedge pclk) begin
      pix_s2 <= shifted[3:0] & bit_mask;       // Zero-extended index
      rgb_s3 <= i_palette[pix_s2*vt_pkg::RGB_W +: vt_pkg::RGB_W];
      o_r    <= widen(rgb_s3[3:0]);
      o_g    <= widen(rgb_s3[7:4]);
      o_b    <= widen(rgb_s3[11:8]);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Sync delay to match

   always_ff @(posedge pclk) begin
      if (i_reset) begin
         de_pipe <= '0;
         hs_pipe <= '0;
         vs_pipe <= '0;
      end else begin
         de_pipe <= {de_pipe[PD-2:0], i_de};
         hs_pipe <= {hs_pipe[PD-2:0], i_hsync};
         vs_pipe <= {vs_pipe[PD-2:0], i_vsync};
      end
   end

   assign o_de    = de_pipe[PD-1];
   assign o_hsync = hs_pipe[PD-1];
   assign o_vsync = vs_pipe[PD-1];
   assign o_blank = ~de_pipe[PD-1];

endmodule

// File: src/video_timing.sv
// Top level of the raster timing generator; joins config, scan, line buffer and pixel pipeline
`timescale 1ns/100ps

module video_timing #(
   parameter int BANK_AW = 8                   // Line buffer bank address bits
) (
   input  logic               pclk,
   input  logic               i_reset,
   // Timing, stable while a request is open
   input  vt_pkg::coord_t     i_t_h_res,
   input  vt_pkg::coord_t     i_t_h_fp,
   input  vt_pkg::coord_t     i_t_h_sync,
   input  vt_pkg::coord_t     i_t_h_bp,
   input  vt_pkg::coord_t     i_t_v_res,
   input  vt_pkg::coord_t     i_t_v_fp,
   input  vt_pkg::coord_t     i_t_v_sync,
   input  vt_pkg::coord_t     i_t_v_bp,
   input  vt_pkg::bpp_t       i_t_bpp,
   input  logic [BANK_AW-1:0] i_words_per_line_m1,
   input  logic               i_cfg_req,
   output logic               o_cfg_ack,
   input  logic               i_flyback,
   // DMA into the line buffer
   input  logic               i_dma_valid,
   input  vt_pkg::word_t      i_dma_data,
   input  logic [vt_pkg::PAL_ENTRIES*vt_pkg::RGB_W-1:0] i_palette,
   // Video out
   output vt_pkg::chan8_t     o_r,
   output vt_pkg::chan8_t     o_g,
   output vt_pkg::chan8_t     o_b,
   output logic               o_hsync,
   output logic               o_vsync,
   output logic               o_de,
   output logic               o_blank
);

   logic               frame_start;
   logic               raw_de;
   logic               raw_hsync;
   logic               raw_vsync;
   vt_pkg::coord_t     disp_x;
   vt_pkg::coord_t     disp_y;
   logic [BANK_AW:0]   rd_addr;
   vt_pkg::word_t      rd_data;

   vt_timing_if u_tim ();

   vt_timing_regs u_regs (
      .pclk, .i_reset, .i_cfg_req, .i_flyback,
      .i_t_h_res, .i_t_h_fp, .i_t_h_sync, .i_t_h_bp,
      .i_t_v_res, .i_t_v_fp, .i_t_v_sync, .i_t_v_bp,
      .i_t_bpp, .o_cfg_ack, .o_frame_start(frame_start), .tim(u_tim.cfg)
   );

   vt_scan_counter u_scan (
      .pclk, .i_reset, .tim(u_tim.scan),
      .o_de(raw_de), .o_hsync(raw_hsync), .o_vsync(raw_vsync),
      .o_disp_x(disp_x), .o_disp_y(disp_y)
   );

   vt_line_buffer #(.BANK_AW(BANK_AW)) u_lbuf (
      .pclk, .i_reset, .i_frame_start(frame_start),
      .i_dma_valid, .i_dma_data, .i_words_per_line_m1,
      .i_rd_addr(rd_addr), .o_rd_data(rd_data)
   );

   vt_pixel_unpack #(.BANK_AW(BANK_AW)) u_pix (
      .pclk, .i_reset, .tim(u_tim.pix),
      .i_de(raw_de), .i_hsync(raw_hsync), .i_vsync(raw_vsync),
      .i_disp_x(disp_x), .i_disp_y(disp_y), .i_palette,
      .o_rd_addr(rd_addr), .i_rd_data(rd_data),
      .o_r, .o_g, .o_b, .o_hsync, .o_vsync, .o_de, .o_blank
   );

endmodule

// File: verif/tb_video_timing.sv
// Testbench for video_timing; drives config, flyback, DMA and palette, checked by assertions
`timescale 1ns/100ps

module tb_video_timing;

   localparam int H_SYNC     = 4;
   localparam int H_RES      = 32;
   localparam int H_TOTAL    = 46;                // 4 + 6 + 32 + 4
   localparam int V_SYNC     = 2;
   localparam int V_RES      = 6;
   localparam int FRAME_CYC  = H_TOTAL * 12;     // 2 + 2 + 6 + 2 lines
   localparam int WATCHDOG_NS = 3 * 8 * FRAME_CYC * 20;

   logic                pclk;
   logic                i_reset;
   vt_pkg::coord_t      i_t_h_res, i_t_h_fp, i_t_h_sync, i_t_h_bp;
   vt_pkg::coord_t      i_t_v_res, i_t_v_fp, i_t_v_sync, i_t_v_bp;
   vt_pkg::bpp_t        i_t_bpp;
   logic [7:0]          i_words_per_line_m1;
   logic                i_cfg_req, i_flyback, i_dma_valid;
   vt_pkg::word_t       i_dma_data;
   logic [191:0]        i_palette;               // 16 entries of 12 bits
   vt_pkg::chan8_t      o_r, o_g, o_b;
   logic                o_cfg_ack, o_hsync, o_vsync, o_de, o_blank;

   // Reference model and output trackers
   logic [31:0]         line_words [16];         // Bank times 8 plus word
   int                  cur_bits;                // Bits per pixel of this pass
   int                  wpl;                     // Words per line
   logic [15:0]         x_cnt, y_cnt, hs_gap, hs_len, vs_len, fb_age, req_age;
   logic [1:0]          falls;                   // Flyback falls since reset, saturating
   logic                de_q, hs_q, vs_q, fb_q, req_q;
   logic                quiet;
   logic [23:0]         rgb_out;

   video_timing i_video_timing (.*);

   initial begin
      pclk = 1'b0;
      forever #10 pclk = ~pclk;
   end

   initial begin
      #(WATCHDOG_NS);
      report_error("watchdog timeout, the test sequence did not finish");
   end

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   function automatic logic [15:0] bump(input logic [15:0] v);
      return (v == 16'hffff) ? v : v + 16'd1;    // Saturating age
   endfunction

   // 4-bit channel becomes the nibble then four copies of its MSB
   function automatic logic [7:0] expand4(input logic [3:0] n);
      return {n, n[3], n[3], n[3], n[3]};
   endfunction

   function automatic logic [23:0] colour_at(input logic [15:0] x, input logic [15:0] y);
      int          ppw;
      logic [31:0] word;
      logic [3:0]  idx;
      logic [11:0] entry;
      ppw   = 32 / cur_bits;
      word  = line_words[(y % 2) * 8 + x / ppw];
      idx   = 4'((word >> ((x % ppw) * cur_bits)) & ((32'd1 << cur_bits) - 1));
      entry = i_palette[idx * 12 +: 12];
      return {expand4(entry[3:0]), expand4(entry[7:4]), expand4(entry[11:8])};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Output trackers

   assign rgb_out = {o_r, o_g, o_b};
   assign quiet   = (falls == 2'd0) || (falls == 2'd1 && fb_age < 16'd4);

   always @(posedge pclk) begin
      de_q  <= o_de;
      hs_q  <= o_hsync;
      vs_q  <= o_vsync;
      fb_q  <= i_flyback;
      req_q <= i_cfg_req;
      if (i_reset) begin
         x_cnt   <= '0;
         y_cnt   <= '0;
         hs_gap  <= '1;
         fb_age  <= '1;
         req_age <= '1;
         falls   <= '0;
      end else begin
         x_cnt   <= o_de ? x_cnt + 16'd1 : '0;        // Also the de run length
         hs_len  <= o_hsync ? hs_len + 16'd1 : '0;
         vs_len  <= o_vsync ? vs_len + 16'd1 : '0;
         hs_gap  <= (o_hsync && !hs_q) ? 16'd1 : bump(hs_gap);
         fb_age  <= (fb_q && !i_flyback) ? 16'd0 : bump(fb_age);
         req_age <= (req_q != i_cfg_req) ? 16'd0 : bump(req_age);
         if (fb_q && !i_flyback && falls != 2'd2)
            falls <= falls + 2'd1;
         if (de_q && !o_de)
            y_cnt <= y_cnt + 16'd1;                    // Display line done
         if (o_vsync && !vs_q)
            y_cnt <= '0;                               // New frame
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks

   a_reset_quiet: assert property (@(posedge pclk) disable iff (i_reset)
      quiet |-> !o_cfg_ack && !o_hsync && !o_vsync && !o_de && o_blank)
      else report_error("outputs active before the first flyback fall after reset");
   // Ack matches req again, shortly after a flyback fall well after the toggle
   a_ack_window: assert property (@(posedge pclk) disable iff (i_reset)
      $changed(o_cfg_ack) |-> o_cfg_ack == i_cfg_req && fb_age <= 4 && req_age >= fb_age + 5)
      else report_error("ack toggled outside the window after a flyback fall");
   a_no_de_pending: assert property (@(posedge pclk) disable iff (i_reset)
      o_cfg_ack != i_cfg_req |-> !o_de)
      else report_error("display enable seen while a timing request was open");
   a_hs_width: assert property (@(posedge pclk) disable iff (i_reset)
      $fell(o_hsync) |-> hs_len == H_SYNC)
      else report_error($sformatf("mismatch hsync_width expected %0d actual %0d",
                                  H_SYNC, $sampled(hs_len)));
   a_hs_period: assert property (@(posedge pclk) disable iff (i_reset)
      $rose(o_hsync) && hs_gap <= FRAME_CYC |-> hs_gap == H_TOTAL)
      else report_error($sformatf("mismatch hsync_period expected %0d actual %0d",
                                  H_TOTAL, $sampled(hs_gap)));
   a_de_width: assert property (@(posedge pclk) disable iff (i_reset)
      $fell(o_de) |-> x_cnt == H_RES)
      else report_error($sformatf("mismatch de_width expected %0d actual %0d",
                                  H_RES, $sampled(x_cnt)));
   a_vs_width: assert property (@(posedge pclk) disable iff (i_reset)
      $fell(o_vsync) |-> vs_len == V_SYNC * H_TOTAL)
      else report_error($sformatf("mismatch vsync_width expected %0d actual %0d",
                                  V_SYNC * H_TOTAL, $sampled(vs_len)));
   a_frame_lines: assert property (@(posedge pclk) disable iff (i_reset)
      $rose(o_vsync) |-> y_cnt == V_RES)
      else report_error($sformatf("mismatch frame_lines expected %0d actual %0d",
                                  V_RES, $sampled(y_cnt)));
   a_pixel: assert property (@(posedge pclk) disable iff (i_reset)
      o_de |-> rgb_out == colour_at(x_cnt, y_cnt))
      else report_error($sformatf("mismatch pixel x=%0d y=%0d expected %h actual %h",
                                  $sampled(x_cnt), $sampled(y_cnt),
                                  colour_at($sampled(x_cnt), $sampled(y_cnt)),
                                  $sampled(rgb_out)));
   a_blank: assert property (@(posedge pclk) disable iff (i_reset)
      o_blank == !o_de)
      else report_error($sformatf("mismatch blank expected %b actual %b",
                                  !$sampled(o_de), $sampled(o_blank)));

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus

   // One frame period; flyback pulse then two lines of DMA words, bank 0 first
   task automatic drive_frame();
      int          n;
      logic [31:0] word;
      i_flyback <= 1'b1;
      repeat (3) @(posedge pclk);
      i_flyback <= 1'b0;
      repeat (6) @(posedge pclk);                      // Past the line buffer restart
      for (n = 0; n < 2 * wpl; n++) begin
         word = $urandom;
         i_dma_valid <= 1'b1;
         i_dma_data  <= word;
         line_words[(n / wpl) * 8 + n % wpl] = word;
         @(posedge pclk);
      end
      i_dma_valid <= 1'b0;
      repeat (FRAME_CYC - 9 - 2 * wpl) @(posedge pclk);
   endtask

   task automatic run_pass(input vt_pkg::bpp_t code, input int bits, input bit new_req);
      cur_bits = bits;
      wpl      = H_RES * bits / 32;
      i_t_bpp             <= code;
      i_words_per_line_m1 <= 8'(wpl - 1);
      if (new_req)
         i_cfg_req <= ~i_cfg_req;
      drive_frame();
      while (o_cfg_ack != i_cfg_req)
         drive_frame();                                // Until the handshake closes
      repeat (3) drive_frame();
   endtask

   initial begin
      int k;
      void'($urandom(3));
      i_reset             <= 1'b1;
      i_t_h_sync          <= vt_pkg::coord_t'(H_SYNC);
      i_t_h_bp            <= 11'd6;
      i_t_h_res           <= vt_pkg::coord_t'(H_RES);
      i_t_h_fp            <= 11'd4;
      i_t_v_sync          <= vt_pkg::coord_t'(V_SYNC);
      i_t_v_bp            <= 11'd2;
      i_t_v_res           <= vt_pkg::coord_t'(V_RES);
      i_t_v_fp            <= 11'd2;
      i_t_bpp             <= vt_pkg::BPP_4;
      i_words_per_line_m1 <= 8'd3;
      i_cfg_req           <= 1'b0;
      i_flyback           <= 1'b0;
      i_dma_valid         <= 1'b0;
      i_dma_data          <= '0;
      for (k = 0; k < 16; k++)
         i_palette[k * 12 +: 12] <= 12'($urandom);
      repeat (4) @(posedge pclk);
      i_reset <= 1'b0;
      @(posedge pclk);
      run_pass(vt_pkg::BPP_4, 4, 1'b0);                // Released by first flyback
      run_pass(vt_pkg::BPP_1, 1, 1'b1);
      run_pass(vt_pkg::BPP_2, 2, 1'b1);
      repeat (10) @(posedge pclk);
      $display("TB PASSED");
      $finish;
   end

endmodule

// File: build.f
src/vt_pkg.sv
src/vt_timing_if.sv
src/vt_timing_regs.sv
src/vt_scan_counter.sv
src/vt_line_buffer.sv
src/vt_pixel_unpack.sv
src/video_timing.sv
verif/tb_video_timing.sv
